// File: test/mem_tests.txt
# kind store size unsigned addr_or_value store_data reg wen exp_result exp_en exp_excp
# size 0 byte 1 half 2 word, excp 0 none 1 inherited 2 load misaligned 3 store misaligned
mem 1 2 0 00000100 11223344 00 0 00000100 0 0
mem 0 2 0 00000100 00000000 01 1 11223344 1 0
mem 1 0 0 00000104 ffffff81 00 0 00000104 0 0
mem 0 2 0 00000104 00000000 02 1 00000081 1 0
alu 0 0 0 0badf00d 00000000 07 1 0badf00d 1 0
mem 1 0 0 00000105 00000092 00 0 00000105 0 0
mem 0 2 0 00000104 00000000 03 1 00009281 1 0
mem 1 0 0 00000106 123456a3 00 0 00000106 0 0
mem 0 2 0 00000104 00000000 04 1 00a39281 1 0
mem 1 0 0 00000107 000000f4 00 0 00000107 0 0
mem 0 2 0 00000104 00000000 05 1 f4a39281 1 0
mem 1 1 0 00000108 1234c5d6 00 0 00000108 0 0
mem 0 2 0 00000108 00000000 06 1 0000c5d6 1 0
mem 1 1 0 0000010a 0000e7f8 00 0 0000010a 0 0
mem 0 2 0 00000108 00000000 07 1 e7f8c5d6 1 0
mem 0 0 0 00000104 00000000 08 1 ffffff81 1 0
mem 0 0 1 00000105 00000000 09 1 00000092 1 0
mem 0 0 0 00000106 00000000 0a 1 ffffffa3 1 0
mem 0 0 1 00000107 00000000 0b 1 000000f4 1 0
mem 0 0 0 00000102 00000000 0c 1 00000022 1 0
mem 0 1 0 00000108 00000000 0d 1 ffffc5d6 1 0
mem 0 1 1 0000010a 00000000 0e 1 0000e7f8 1 0
mem 0 1 0 00000100 00000000 0f 1 00003344 1 0
mem 1 1 0 00000109 0000ffff 00 0 00000109 0 3
mem 1 2 0 0000010e deadbeef 00 0 0000010e 0 3
mem 0 2 0 00000102 00000000 10 1 00000102 0 2
mem 0 1 0 0000010d 00000000 11 1 0000010d 0 2
mem 0 2 0 00000108 00000000 12 1 e7f8c5d6 1 0
mem 0 2 0 0000010c 00000000 13 1 00000000 1 0
excp 0 2 0 00000040 00000000 14 1 00000040 0 1
alu 0 0 0 ffffffff 00000000 00 0 ffffffff 0 0

// File: list.f
+incdir+src
src/mem_access_pkg.sv
src/mem_wb_pkg.sv
src/store_align.sv
src/load_extract.sv
src/mem_stage.sv
src/data_sram.sv
src/mem_subsystem.sv
test/mem_subsystem_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps -j 0 \
    -f list.f \
    --top-module mem_subsystem_tb \
    --Mdir obj_dir \
    -o mem_subsystem_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed"
    exit "$status"
fi

./obj_dir/mem_subsystem_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit "$status"
fi
exit 0

// File: test/mem_subsystem_tb.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module mem_subsystem_tb;
    import mem_access_pkg::*;
    import mem_wb_pkg::*;

    // one access from the stimulus file
    typedef struct {
        logic             is_mem;
        logic             excp;
        logic             store;
        logic [1:0]       size;
        logic             unsign;
        logic [`XLEN-1:0] value;
        logic [`XLEN-1:0] sdata;
        reg_idx_t         idx;
        logic             wen;
        logic [`XLEN-1:0] exp_result;
        logic             exp_en;
        logic [1:0]       exp_excp;
    } test_line_t;

    logic             clk = 1'b0;
    logic             rst_i = 1'b1;
    logic             flush_i = 1'b0;
    logic             in_valid_i = 1'b0;
    logic             in_ready_o;
    logic             is_mem_i = 1'b0;
    logic             is_store_i = 1'b0;
    mem_size_e        size_i = SIZE_BYTE;
    logic             unsigned_i = 1'b0;
    logic [`XLEN-1:0] alu_result_i = '0;
    logic [`XLEN-1:0] store_data_i = '0;
    reg_idx_t         wreg_idx_i = '0;
    logic             wreg_en_i = 1'b0;
    logic             excp_in_i = 1'b0;
    logic             out_valid_o;
    logic             out_ready_i = 1'b0;
    logic [`XLEN-1:0] wb_result_o;
    reg_idx_t         wb_idx_o;
    logic             wb_en_o;
    excp_code_e       wb_excp_o;
    logic [`XLEN-1:0] byp_result_o;
    reg_idx_t         byp_idx_o;
    logic             byp_en_o;

    test_line_t  tests[$];
    // indices of accepted instructions still owed a writeback
    int          pending[$];
    int          next_in = 0;
    int          checked = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    logic        running = 1'b0;
    logic [15:0] lfsr = 16'd12;

    mem_subsystem uut (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .is_mem_i     (is_mem_i),
        .is_store_i   (is_store_i),
        .size_i       (size_i),
        .unsigned_i   (unsigned_i),
        .alu_result_i (alu_result_i),
        .store_data_i (store_data_i),
        .wreg_idx_i   (wreg_idx_i),
        .wreg_en_i    (wreg_en_i),
        .excp_in_i    (excp_in_i),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .wb_result_o  (wb_result_o),
        .wb_idx_o     (wb_idx_o),
        .wb_en_o      (wb_en_o),
        .wb_excp_o    (wb_excp_o),
        .byp_result_o (byp_result_o),
        .byp_idx_o    (byp_idx_o),
        .byp_en_o     (byp_en_o)
    );

    always #2 clk = ~clk;

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task read_tests();
        int          fd;
        int          n;
        logic        at_end;
        string       kind;
        string       rest;
        logic [31:0] f_store;
        logic [31:0] f_size;
        logic [31:0] f_uns;
        logic [31:0] f_value;
        logic [31:0] f_sdata;
        logic [31:0] f_idx;
        logic [31:0] f_wen;
        logic [31:0] f_res;
        logic [31:0] f_en;
        logic [31:0] f_excp;
        test_line_t  t;
        fd = $fopen("test/mem_tests.txt", "r");
        assert (fd != 0) else begin
            $display("could not open test/mem_tests.txt");
            abort_run();
        end
        at_end = 1'b0;
        while (!at_end) begin
            n = $fscanf(fd, "%s", kind);
            if (n != 1) begin
                at_end = 1'b1;
            end else if (kind.substr(0, 0) == "#") begin
                // comment line is skipped to its end
                n = $fgets(rest, fd);
            end else begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h",
                            f_store, f_size, f_uns, f_value, f_sdata,
                            f_idx, f_wen, f_res, f_en, f_excp);
                assert (n == 10 && (kind == "mem" || kind == "alu" || kind == "excp")) else begin
                    $display("malformed entry after %0d tests in the test file", tests.size());
                    abort_run();
                end
                t.is_mem     = (kind == "mem");
                t.excp       = (kind == "excp");
                t.store      = f_store[0];
                t.size       = f_size[1:0];
                t.unsign     = f_uns[0];
                t.value      = f_value;
                t.sdata      = f_sdata;
                t.idx        = f_idx[`REG_IDX_W-1:0];
                t.wen        = f_wen[0];
                t.exp_result = f_res;
                t.exp_en     = f_en[0];
                t.exp_excp   = f_excp[1:0];
                tests.push_back(t);
            end
        end
        $fclose(fd);
        assert (tests.size() != 0) else begin
            $display("the test file holds no tests");
            abort_run();
        end
    endtask

    task drive_line(input int i);
        in_valid_i   <= 1'b1;
        is_mem_i     <= tests[i].is_mem;
        is_store_i   <= tests[i].store;
        size_i       <= mem_size_e'(tests[i].size);
        unsigned_i   <= tests[i].unsign;
        alu_result_i <= tests[i].value;
        store_data_i <= tests[i].sdata;
        wreg_idx_i   <= tests[i].idx;
        wreg_en_i    <= tests[i].wen;
        excp_in_i    <= tests[i].excp;
    endtask

    task check_writeback();
        int         i;
        test_line_t t;
        assert (pending.size() != 0) else begin
            $display("writeback delivered a result with no instruction outstanding");
            abort_run();
        end
        i = pending.pop_front();
        t = tests[i];
        assert (wb_result_o == t.exp_result) else begin
            $display("FAIL wb_result_o test %0d: got %h expected %h", i, wb_result_o,
                     t.exp_result);
            abort_run();
        end
        assert (wb_idx_o == t.idx) else begin
            $display("FAIL wb_idx_o test %0d: got %h expected %h", i, wb_idx_o, t.idx);
            abort_run();
        end
        assert (wb_en_o == t.exp_en) else begin
            $display("FAIL wb_en_o test %0d: got %h expected %h", i, wb_en_o, t.exp_en);
            abort_run();
        end
        assert (wb_excp_o == t.exp_excp) else begin
            $display("FAIL wb_excp_o test %0d: got %h expected %h", i, wb_excp_o, t.exp_excp);
            abort_run();
        end
        checked = checked + 1;
    endtask

    // the accepted instruction is done, so its bypass must be live
    task compare_bypass(input int i);
        assert (byp_en_o == tests[i].exp_en) else begin
            $display("FAIL byp_en_o test %0d: got %h expected %h", i, byp_en_o,
                     tests[i].exp_en);
            abort_run();
        end
        assert (byp_result_o == tests[i].exp_result) else begin
            $display("FAIL byp_result_o test %0d: got %h expected %h", i, byp_result_o,
                     tests[i].exp_result);
            abort_run();
        end
        assert (byp_idx_o == tests[i].idx) else begin
            $display("FAIL byp_idx_o test %0d: got %h expected %h", i, byp_idx_o,
                     tests[i].idx);
            abort_run();
        end
    endtask

    initial begin
        read_tests();
        cycle_limit = 20 * tests.size() + 50;
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;
        @(posedge clk);
        // idle state straight out of reset
        assert (out_valid_o == 1'b0) else begin
            $display("FAIL out_valid_o after reset: got %h expected %h", out_valid_o, 1'b0);
            abort_run();
        end
        assert (in_ready_o == 1'b1) else begin
            $display("FAIL in_ready_o after reset: got %h expected %h", in_ready_o, 1'b1);
            abort_run();
        end
        running <= 1'b1;
    end

    always @(posedge clk) begin
        if (running) begin
            cycles = cycles + 1;
            assert (cycles <= cycle_limit) else begin
                $display("timeout with %0d of %0d results after %0d cycles", checked,
                         tests.size(), cycles);
                abort_run();
            end
            if (out_valid_o && out_ready_i) begin
                check_writeback();
            end
            if (in_valid_i && in_ready_o) begin
                compare_bypass(next_in);
                pending.push_back(next_in);
                next_in = next_in + 1;
            end else if (in_valid_i && out_ready_i) begin
                // access still waiting on the sram
                assert (byp_en_o == 1'b0) else begin
                    $display("FAIL byp_en_o test %0d: got %h expected %h", next_in,
                             byp_en_o, 1'b0);
                    abort_run();
                end
            end
            if (next_in < tests.size()) begin
                drive_line(next_in);
            end else begin
                in_valid_i <= 1'b0;
            end
            // random back-pressure from writeback
            lfsr = lfsr_next(lfsr);
            out_ready_i <= lfsr[0];
            if (checked == tests.size()) begin
                $display("Everything OK");
                $finish;
            end
        end
    end

endmodule

// File: src/mem_subsystem.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module mem_subsystem (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       flush_i,
    // execute side
    input  logic                       in_valid_i,
    output logic                       in_ready_o,
    input  logic                       is_mem_i,
    input  logic                       is_store_i,
    input  mem_access_pkg::mem_size_e  size_i,
    input  logic                       unsigned_i,
    input  logic [`XLEN-1:0]           alu_result_i,
    input  logic [`XLEN-1:0]           store_data_i,
    input  mem_wb_pkg::reg_idx_t       wreg_idx_i,
    input  logic                       wreg_en_i,
    input  logic                       excp_in_i,
    // writeback side
    output logic                       out_valid_o,
    input  logic                       out_ready_i,
    output logic [`XLEN-1:0]           wb_result_o,
    output mem_wb_pkg::reg_idx_t       wb_idx_o,
    output logic                       wb_en_o,
    output mem_access_pkg::excp_code_e wb_excp_o,
    // bypass
    output logic [`XLEN-1:0]           byp_result_o,
    output mem_wb_pkg::reg_idx_t       byp_idx_o,
    output logic                       byp_en_o
);
    logic             sram_req;
    logic             sram_we;
    logic [`XLEN-1:0] sram_addr;
    logic [3:0]       sram_wmask;
    logic [`XLEN-1:0] sram_wdata;
    logic             sram_done;
    logic [`XLEN-1:0] sram_rdata;

    mem_stage u_stage (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .is_mem_i     (is_mem_i),
        .is_store_i   (is_store_i),
        .size_i       (size_i),
        .unsigned_i   (unsigned_i),
        .alu_result_i (alu_result_i),
        .store_data_i (store_data_i),
        .wreg_idx_i   (wreg_idx_i),
        .wreg_en_i    (wreg_en_i),
        .excp_in_i    (excp_in_i),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .wb_result_o  (wb_result_o),
        .wb_idx_o     (wb_idx_o),
        .wb_en_o      (wb_en_o),
        .wb_excp_o    (wb_excp_o),
        .byp_result_o (byp_result_o),
        .byp_idx_o    (byp_idx_o),
        .byp_en_o     (byp_en_o),
        .req_o        (sram_req),
        .we_o         (sram_we),
        .addr_o       (sram_addr),
        .wmask_o      (sram_wmask),
        .wdata_o      (sram_wdata),
        .done_i       (sram_done),
        .rdata_i      (sram_rdata)
    );

    data_sram u_sram (
        .clk     (clk),
        .rst_i   (rst_i),
        .req_i   (sram_req),
        .we_i    (sram_we),
        .addr_i  (sram_addr),
        .wmask_i (sram_wmask),
        .wdata_i (sram_wdata),
        .done_o  (sram_done),
        .rdata_o (sram_rdata)
    );

endmodule

// File: src/data_sram.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module data_sram (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             req_i,
    input  logic             we_i,
    input  logic [`XLEN-1:0] addr_i,
    input  logic [3:0]       wmask_i,
    input  logic [`XLEN-1:0] wdata_i,
    output logic             done_o,
    output logic [`XLEN-1:0] rdata_o
);
    localparam int IDX_W = $clog2(`SRAM_WORDS);
    localparam int CNT_W = 3;

    logic [`XLEN-1:0] mem_q [`SRAM_WORDS];
    logic [IDX_W-1:0] idx_q;
    logic             we_q;
    logic [3:0]       wmask_q;
    logic [`XLEN-1:0] wdata_q;
    logic [`XLEN-1:0] rdata_q;
    logic [CNT_W-1:0] cnt_q;

    // latency counter with done on the last count
    always_ff @(posedge clk) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (req_i) begin
            cnt_q <= CNT_W'(`SRAM_LAT_BASE) + CNT_W'(addr_i[3:2]);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - CNT_W'(1);
        end
    end

    assign done_o = (cnt_q == CNT_W'(1));

    // request capture and array read
    always_ff @(posedge clk) begin
        if (req_i) begin
            idx_q   <= addr_i[IDX_W+1:2];
            we_q    <= we_i;
            wmask_q <= wmask_i;
            wdata_q <= wdata_i;
            rdata_q <= mem_q[addr_i[IDX_W+1:2]];
        end
    end

    assign rdata_o = rdata_q;

    // masked write lands when the access completes
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `SRAM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (done_o && we_q) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask_q[b]) begin
                    mem_q[idx_q][8*b +: 8] <= wdata_q[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: src/mem_stage.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module mem_stage (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       flush_i,
    // from execute
    input  logic                       in_valid_i,
    output logic                       in_ready_o,
    input  logic                       is_mem_i,
    input  logic                       is_store_i,
    input  mem_access_pkg::mem_size_e  size_i,
    input  logic                       unsigned_i,
    input  logic [`XLEN-1:0]           alu_result_i,
    input  logic [`XLEN-1:0]           store_data_i,
    input  mem_wb_pkg::reg_idx_t       wreg_idx_i,
    input  logic                       wreg_en_i,
    input  logic                       excp_in_i,
    // to writeback
    output logic                       out_valid_o,
    input  logic                       out_ready_i,
    output logic [`XLEN-1:0]           wb_result_o,
    output mem_wb_pkg::reg_idx_t       wb_idx_o,
    output logic                       wb_en_o,
    output mem_access_pkg::excp_code_e wb_excp_o,
    // bypass toward execute
    output logic [`XLEN-1:0]           byp_result_o,
    output mem_wb_pkg::reg_idx_t       byp_idx_o,
    output logic                       byp_en_o,
    // data sram
    output logic                       req_o,
    output logic                       we_o,
    output logic [`XLEN-1:0]           addr_o,
    output logic [3:0]                 wmask_o,
    output logic [`XLEN-1:0]           wdata_o,
    input  logic                       done_i,
    input  logic [`XLEN-1:0]           rdata_i
);
    import mem_access_pkg::*;

    logic             misaligned;
    excp_code_e       excp_code;
    logic             excp_any;
    logic             clean_mem;
    logic             issued_q;
    logic             drop_q;
    logic             mem_done_q;
    logic [`XLEN-1:0] rdata_q;
    logic             resp_hit;
    logic             cur_done;
    logic             fire;
    logic [`XLEN-1:0] load_data;
    logic [`XLEN-1:0] load_value;
    logic [`XLEN-1:0] result;

    // alignment check
    always_comb begin
        case (size_i)
            SIZE_HALF: misaligned = alu_result_i[0];
            SIZE_WORD: misaligned = |alu_result_i[1:0];
            default:   misaligned = 1'b0;
        endcase
    end

    always_comb begin
        if (excp_in_i) begin
            excp_code = EXCP_INHERIT;
        end else if (is_mem_i && misaligned && is_store_i) begin
            excp_code = EXCP_STORE_MISALIGN;
        end else if (is_mem_i && misaligned) begin
            excp_code = EXCP_LOAD_MISALIGN;
        end else begin
            excp_code = EXCP_NONE;
        end
    end

    assign excp_any  = (excp_code != EXCP_NONE);
    // only clean accesses reach the sram
    assign clean_mem = is_mem_i && !excp_any;

    // completion that belongs to the instruction in the stage
    assign resp_hit   = issued_q && done_i && !drop_q;
    assign cur_done   = in_valid_i && (!clean_mem || resp_hit || mem_done_q);
    assign fire       = cur_done && out_ready_i;
    assign in_ready_o = !in_valid_i || fire;

    // one request per instruction
    assign req_o  = in_valid_i && clean_mem && !issued_q && !mem_done_q && !flush_i;
    assign we_o   = is_store_i;
    assign addr_o = alu_result_i;

    store_align u_store_align (
        .size_i    (size_i),
        .addr_lo_i (alu_result_i[1:0]),
        .data_i    (store_data_i),
        .wdata_o   (wdata_o),
        .wmask_o   (wmask_o)
    );

    // held copy is used when writeback stalls after done
    assign load_data = mem_done_q ? rdata_q : rdata_i;

    load_extract u_load_extract (
        .size_i     (size_i),
        .unsigned_i (unsigned_i),
        .addr_lo_i  (alu_result_i[1:0]),
        .rdata_i    (load_data),
        .value_o    (load_value)
    );

    assign result = (clean_mem && !is_store_i) ? load_value : alu_result_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            issued_q    <= 1'b0;
            drop_q      <= 1'b0;
            mem_done_q  <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            if (req_o) begin
                issued_q <= 1'b1;
            end
            if (done_i) begin
                issued_q <= 1'b0;
                drop_q   <= 1'b0;
            end else if (flush_i && issued_q) begin
                // the access in flight still completes and its done is dropped
                drop_q <= 1'b1;
            end
            if (flush_i || fire) begin
                mem_done_q <= 1'b0;
            end else if (resp_hit) begin
                mem_done_q <= 1'b1;
            end
            if (flush_i) begin
                out_valid_o <= 1'b0;
            end else if (out_ready_i) begin
                out_valid_o <= cur_done;
            end
        end
    end

    // writeback payload
    always_ff @(posedge clk) begin
        if (resp_hit) begin
            rdata_q <= rdata_i;
        end
        if (fire) begin
            wb_result_o <= result;
            wb_idx_o    <= wreg_idx_i;
            wb_en_o     <= wreg_en_i && !excp_any;
            wb_excp_o   <= excp_code;
        end
    end

    assign byp_result_o = result;
    assign byp_idx_o    = wreg_idx_i;
    assign byp_en_o     = cur_done && wreg_en_i && !excp_any;

endmodule

// File: src/load_extract.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module load_extract (
    input  mem_access_pkg::mem_size_e size_i,
    input  logic                      unsigned_i,
    input  logic [1:0]                addr_lo_i,
    input  logic [`XLEN-1:0]          rdata_i,
    output logic [`XLEN-1:0]          value_o
);
    import mem_access_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic        byte_fill;
    logic        half_fill;

    // lane select
    assign byte_sel = rdata_i[8*addr_lo_i +: 8];
    assign half_sel = addr_lo_i[1] ? rdata_i[31:16] : rdata_i[15:0];

    // fill bit is zero for unsigned loads
    assign byte_fill = byte_sel[7] & ~unsigned_i;
    assign half_fill = half_sel[15] & ~unsigned_i;

    always_comb begin
        case (size_i)
            SIZE_BYTE: begin
                value_o = {{(`XLEN-8){byte_fill}}, byte_sel};
            end
            SIZE_HALF: begin
                value_o = {{(`XLEN-16){half_fill}}, half_sel};
            end
            default: begin
                value_o = rdata_i;
            end
        endcase
    end

endmodule

// File: src/store_align.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module store_align (
    input  mem_access_pkg::mem_size_e size_i,
    input  logic [1:0]                addr_lo_i,
    input  logic [`XLEN-1:0]          data_i,
    output logic [`XLEN-1:0]          wdata_o,
    output logic [3:0]                wmask_o
);
    import mem_access_pkg::*;

    // data is replicated on every lane
    // the mask picks the live ones
    always_comb begin
        case (size_i)
            SIZE_BYTE: begin
                wdata_o = {4{data_i[7:0]}};
                wmask_o = 4'b0001 << addr_lo_i;
            end
            SIZE_HALF: begin
                wdata_o = {2{data_i[15:0]}};
                // bit 0 is already checked by the stage
                wmask_o = addr_lo_i[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wdata_o = data_i;
                wmask_o = 4'b1111;
            end
        endcase
    end

endmodule

// File: src/mem_wb_pkg.sv
`include "mem_macros.svh"

package mem_wb_pkg;

    // destination register index
    // shared by writeback and the bypass toward execute
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

endpackage

// File: src/mem_access_pkg.sv
package mem_access_pkg;

    // access size as decoded by execute
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    // exception reported toward writeback
    // inherited codes win over a local misalignment
    typedef enum logic [1:0] {
        EXCP_NONE           = 2'd0,
        EXCP_INHERIT        = 2'd1,
        EXCP_LOAD_MISALIGN  = 2'd2,
        EXCP_STORE_MISALIGN = 2'd3
    } excp_code_e;

endpackage

// File: src/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// data and address width
`define XLEN 32

// register index width
`define REG_IDX_W 5

// data sram depth in words
// word index comes from address bits 9..2
`define SRAM_WORDS 256

// shortest response latency in cycles
// address bits 3..2 add up to three more
`define SRAM_LAT_BASE 1

`endif
